// ==== include/gpio_seq_defs.svh ====
/*
 * Shared sizes for the GPIO walking-pin sequencer
 * Pin count, counter widths, bus widths, default ticks per unit
 */

`ifndef GPIO_SEQ_DEFS_SVH
`define GPIO_SEQ_DEFS_SVH

// Sequenced output pins
`define GPIO_NUM_PINS 34
`define GPIO_CNT_W 6         // Pin counter, holds 0 to 34

// Time-unit divider
`define GPIO_PRESCALER_W 14  // Units per pin
`define GPIO_DIV_W 28        // Fits prescaler max times ticks per unit

// Strobe bus
`define GPIO_BUS_DW 16
`define GPIO_BUS_AW 2

// 10 MHz clock, one unit is 1 ms
`define GPIO_TICKS_PER_MS 10000

`endif

// ==== design/gpio_seq_pkg.sv ====
/*
 * Shared types for the GPIO sequencer
 * Register address enum, sequencer state enum
 */

`include "gpio_seq_defs.svh"

package gpio_seq_pkg;

    // Register map on the strobe bus
    typedef enum logic [`GPIO_BUS_AW-1:0] {
        REG_CTRL     = 2'd0, // Enable, one-shot
        REG_PRESCALE = 2'd1, // Units per pin
        REG_CMD      = 2'd2, // Stop, irq clear, write only
        REG_STATUS   = 2'd3  // Running, irq, pin count, read only
    } reg_addr_e;

    // Run state of the walk
    typedef enum logic [1:0] {
        SEQ_IDLE,     // Counters cleared, gpio low
        SEQ_RUN,      // Walking
        SEQ_FINISHED  // One-shot walk over, waits for enable low
    } seq_state_e;

endpackage

// ==== design/flex_counter.sv ====
/*
 * Parameterized up-counter
 * Enable, synchronous clear, programmable rollover, registered flag
 */

`timescale 1ns/1ns

module flex_counter #(
    parameter int NUM_CNT_BITS = 4
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    count_enable,
    input  logic                    clear,
    input  logic [NUM_CNT_BITS-1:0] rollover_val,
    output logic [NUM_CNT_BITS-1:0] count_out,
    output logic                    rollover_flag
);
    logic [NUM_CNT_BITS-1:0] next_count;
    logic                    next_flag;
    logic                    roll_valid;

    // Zero rollover means never wrap and never flag
    assign roll_valid = (rollover_val != '0);

    always_comb begin
        // Back to 1 once the limit is reached, also if the limit dropped below count
        if (roll_valid && count_out >= rollover_val)
            next_count = NUM_CNT_BITS'(1);
        else
            next_count = count_out + 1'b1;
        next_flag = roll_valid && (next_count == rollover_val); // Flag lines up with count
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_out     <= '0;
            rollover_flag <= 1'b0;
        end else if (clear) begin  // Clear wins over enable
            count_out     <= '0;
            rollover_flag <= 1'b0;
        end else if (count_enable) begin
            count_out     <= next_count;
            rollover_flag <= next_flag;
        end
        // Disabled cycles hold both
    end

    // Flag only ever marks a nonzero count
    a_flag_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n)
        rollover_flag |-> (count_out != '0)
    );

endmodule

// ==== design/pin_sequencer.sv ====
/*
 * Walking-pin sequencer
 * Run-state FSM, time-unit divider, pin counter, one-hot gpio register
 * Raises pin 0 to pin 33 in turn, each for prescaler x TICKS_PER_UNIT cycles
 */

`timescale 1ns/1ns
`include "gpio_seq_defs.svh"

module pin_sequencer #(
    parameter int TICKS_PER_UNIT = `GPIO_TICKS_PER_MS
) (
    input  logic                         clk,       // 10 MHz
    input  logic                         arst_n,
    input  logic                         run_en,    // CTRL.enable level
    input  logic                         one_shot,  // Stop after pin 33
    input  logic                         stop_req,  // One-cycle stop
    input  logic [`GPIO_PRESCALER_W-1:0] prescaler,
    output gpio_seq_pkg::seq_state_e     seq_state,
    output logic [`GPIO_CNT_W-1:0]       pin_count, // 0 none, n means pin n-1 high
    output logic                         walk_done, // Pulse as pin 33 ends
    output logic [`GPIO_NUM_PINS-1:0]    gpio
);
    localparam int DIV_W    = `GPIO_DIV_W;
    localparam int CNT_W    = `GPIO_CNT_W;
    localparam int NUM_PINS = `GPIO_NUM_PINS;

    gpio_seq_pkg::seq_state_e next_state;

    logic             advance;     // Walk may progress this cycle
    logic             div_enable;
    logic             div_flag;
    logic             unit_tick;   // One cycle per pin period
    logic             pin_roll;    // Pin counter sits at 34
    logic             pin_clear;
    logic [DIV_W-1:0] unit_period; // Cycles per pin
    logic [CNT_W-1:0] next_index;  // Pin to raise on the next tick
    logic [NUM_PINS-1:0] gpio_d;

    assign advance     = (seq_state == gpio_seq_pkg::SEQ_RUN) && run_en && !stop_req;
    assign unit_period = DIV_W'(prescaler) * DIV_W'(TICKS_PER_UNIT);
    assign div_enable  = advance && (prescaler != '0); // Zero prescaler holds the walk
    assign unit_tick   = div_flag && div_enable;
    assign walk_done   = unit_tick && pin_roll;
    assign pin_clear   = !advance || (walk_done && one_shot); // Last pin of a one-shot

    // Time-unit divider
    flex_counter #(.NUM_CNT_BITS(DIV_W)) unit_divider (
        .clk          (clk),
        .arst_n       (arst_n),
        .count_enable (div_enable),
        .clear        (!advance),
        .rollover_val (unit_period),
        .count_out    (),
        .rollover_flag(div_flag)
    );

    // Pin counter, 1 to 34
    flex_counter #(.NUM_CNT_BITS(CNT_W)) pin_counter (
        .clk          (clk),
        .arst_n       (arst_n),
        .count_enable (unit_tick),
        .clear        (pin_clear),
        .rollover_val (CNT_W'(NUM_PINS)),
        .count_out    (pin_count),
        .rollover_flag(pin_roll)
    );

    always_comb begin
        next_state = seq_state;
        case (seq_state)
            gpio_seq_pkg::SEQ_IDLE:
                if (run_en && !stop_req) next_state = gpio_seq_pkg::SEQ_RUN;
            gpio_seq_pkg::SEQ_RUN:
                if (!run_en || stop_req)      next_state = gpio_seq_pkg::SEQ_IDLE;
                else if (walk_done && one_shot) next_state = gpio_seq_pkg::SEQ_FINISHED;
            gpio_seq_pkg::SEQ_FINISHED:
                if (!run_en || stop_req) next_state = gpio_seq_pkg::SEQ_IDLE;
            default: next_state = gpio_seq_pkg::SEQ_IDLE;
        endcase
    end

    // Next pin is count-1 after the increment, so index equals current count
    assign next_index = pin_roll ? '0 : pin_count; // 33 wraps to 0

    always_comb begin
        gpio_d = gpio;                                   // Hold between ticks
        if (!advance)
            gpio_d = '0;                                 // Stop or leaving RUN
        else if (unit_tick)
            gpio_d = (pin_roll && one_shot) ? '0 : NUM_PINS'(1) << next_index;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seq_state <= gpio_seq_pkg::SEQ_IDLE;
            gpio      <= '0;
        end else begin
            seq_state <= next_state;
            gpio      <= gpio_d;    // Moves on the same edge as pin_count
        end
    end

    a_gpio_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(gpio)
    );

    // No pin high unless walking
    a_gpio_run_only: assert property (
        @(posedge clk) disable iff (!arst_n)
        (gpio != '0) |-> (seq_state == gpio_seq_pkg::SEQ_RUN)
    );

endmodule

// ==== design/seq_config_regs.sv ====
/*
 * Register block for the walking-pin sequencer
 * CTRL, PRESCALE, CMD and STATUS on a single-cycle strobe bus
 * Stop pulse and sticky one-shot interrupt
 */

`timescale 1ns/1ns
`include "gpio_seq_defs.svh"

module seq_config_regs (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         wr_en,     // One-cycle write strobe
    input  logic                         rd_en,     // One-cycle read strobe
    input  logic [`GPIO_BUS_AW-1:0]      addr,
    input  logic [`GPIO_BUS_DW-1:0]      wdata,
    output logic [`GPIO_BUS_DW-1:0]      rdata,     // Valid with rd_valid
    output logic                         rd_valid,
    output logic                         run_en,    // CTRL bit 0
    output logic                         one_shot,  // CTRL bit 1
    output logic [`GPIO_PRESCALER_W-1:0] prescaler,
    output logic                         stop_req,
    input  gpio_seq_pkg::seq_state_e     seq_state,
    input  logic [`GPIO_CNT_W-1:0]       pin_count,
    input  logic                         walk_done,
    output logic                         irq        // Sticky, one-shot end
);
    localparam int DW = `GPIO_BUS_DW;
    localparam int PW = `GPIO_PRESCALER_W;

    gpio_seq_pkg::reg_addr_e reg_sel;

    logic          wr_ctrl;
    logic          wr_prescale;
    logic          wr_cmd;
    logic          stop_cmd;
    logic          irq_set;
    logic          irq_clr;
    logic          running;
    logic [DW-1:0] status_word;
    logic [DW-1:0] read_mux;

    assign reg_sel     = gpio_seq_pkg::reg_addr_e'(addr);
    assign wr_ctrl     = wr_en && (reg_sel == gpio_seq_pkg::REG_CTRL);
    assign wr_prescale = wr_en && (reg_sel == gpio_seq_pkg::REG_PRESCALE);
    assign wr_cmd      = wr_en && (reg_sel == gpio_seq_pkg::REG_CMD);
    assign stop_cmd    = wr_cmd && wdata[0];
    assign irq_clr     = wr_cmd && wdata[1];
    assign irq_set     = walk_done && one_shot; // End of a one-shot walk
    assign running     = (seq_state == gpio_seq_pkg::SEQ_RUN);

    always_comb begin
        status_word       = '0;
        status_word[0]    = running;
        status_word[1]    = irq;       // Pending interrupt
        status_word[13:8] = pin_count;
    end

    always_comb begin
        case (reg_sel)
            gpio_seq_pkg::REG_CTRL:     read_mux = DW'({one_shot, run_en});
            gpio_seq_pkg::REG_PRESCALE: read_mux = DW'(prescaler);
            gpio_seq_pkg::REG_STATUS:   read_mux = status_word;
            default:                    read_mux = '0; // CMD reads 0
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_en    <= 1'b0;
            one_shot  <= 1'b0;
            prescaler <= '0;
            stop_req  <= 1'b0;
            irq       <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            stop_req <= stop_cmd;        // One-cycle pulse
            rd_valid <= rd_en;
            if (wr_ctrl) begin
                run_en   <= wdata[0];
                one_shot <= wdata[1];
            end else if (stop_cmd) begin
                run_en <= 1'b0;          // Stop drops the enable
            end
            if (wr_prescale)
                prescaler <= wdata[PW-1:0];
            // Set beats a same-cycle clear
            if (irq_set)
                irq <= 1'b1;
            else if (irq_clr)
                irq <= 1'b0;
        end
    end

    // Read data, only loaded on a strobe
    always_ff @(posedge clk) begin
        if (rd_en)
            rdata <= read_mux;
    end

    // rd_valid answers a read strobe one cycle later and never on its own
    a_rd_valid_follows: assert property (
        @(posedge clk) disable iff (!arst_n)
        rd_valid |-> $past(rd_en)
    );

endmodule

// ==== design/gpio_seq_top.sv ====
/*
 * Top level of the GPIO walking-pin sequencer
 * Register block beside the sequencer it configures
 */

`timescale 1ns/1ns
`include "gpio_seq_defs.svh"

module gpio_seq_top #(
    parameter int TICKS_PER_UNIT = `GPIO_TICKS_PER_MS // Cycles per prescaler unit
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  logic [`GPIO_BUS_AW-1:0]   addr,
    input  logic [`GPIO_BUS_DW-1:0]   wdata,
    output logic [`GPIO_BUS_DW-1:0]   rdata,
    output logic                      rd_valid,
    output logic                      irq,      // To the management core
    output logic [`GPIO_NUM_PINS-1:0] gpio      // Breakout pins
);
    // Config to sequencer
    logic                         run_en;
    logic                         one_shot;
    logic [`GPIO_PRESCALER_W-1:0] prescaler;
    logic                         stop_req;

    // Sequencer status back
    gpio_seq_pkg::seq_state_e     seq_state;
    logic [`GPIO_CNT_W-1:0]       pin_count;
    logic                         walk_done;

    seq_config_regs regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .rd_en     (rd_en),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .rd_valid  (rd_valid),
        .run_en    (run_en),
        .one_shot  (one_shot),
        .prescaler (prescaler),
        .stop_req  (stop_req),
        .seq_state (seq_state),
        .pin_count (pin_count),
        .walk_done (walk_done),
        .irq       (irq)
    );

    pin_sequencer #(.TICKS_PER_UNIT(TICKS_PER_UNIT)) sequencer (
        .clk       (clk),
        .arst_n    (arst_n),
        .run_en    (run_en),
        .one_shot  (one_shot),
        .stop_req  (stop_req),
        .prescaler (prescaler),
        .seq_state (seq_state),
        .pin_count (pin_count),
        .walk_done (walk_done),
        .gpio      (gpio)
    );

endmodule

// ==== tb/gpio_seq_tb.sv ====
/*
 * Testbench for the GPIO walking-pin sequencer
 * Clock, reset, LFSR, strobe bus tasks and stimulus
 * Concurrent checks on pin order, pin period, status, interrupt and stop
 */

`timescale 1ns/1ns
`include "gpio_seq_defs.svh"

module gpio_seq_tb;
    localparam int TICKS = 4;                   // Short units for simulation
    localparam int NPINS = `GPIO_NUM_PINS;

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    wr_en;
    logic                    rd_en;
    logic [`GPIO_BUS_AW-1:0] addr;
    logic [`GPIO_BUS_DW-1:0] wdata;
    logic [`GPIO_BUS_DW-1:0] rdata;
    logic                    rd_valid;
    logic                    irq;
    logic [NPINS-1:0]        gpio;

    // Checker state, one cycle behind the DUT
    logic [NPINS-1:0]        prev_gpio = '0;
    logic                    prev_irq = 1'b0;
    logic                    prev_clr = 1'b0;      // irq clear written last cycle
    logic [`GPIO_BUS_AW-1:0] prev_addr = '0;
    logic [1:0]              stop_dly = '0;        // Stop write two cycles back
    int                      hold_cnt = 0;         // Cycles the current gpio value held
    int                      cur_prescale = 0;     // Last PRESCALE written
    logic                    quiet = 1'b0;         // No pin may be high
    logic                    chk_rd = 1'b0;
    logic [`GPIO_BUS_DW-1:0] exp_rd = '0;
    logic [`GPIO_BUS_DW-1:0] exp_mask = '0;
    string                   chk_name = "";
    int                      err_cnt = 0;
    int                      tmo_cnt = 0;
    logic [31:0]             lfsr = 32'h2bf0af77;
    int                      pre;

    gpio_seq_top #(.TICKS_PER_UNIT(TICKS)) gpio_seq_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .irq      (irq),
        .gpio     (gpio)
    );

    always #50 clk = ~clk;  // 100 ns period

    function automatic logic [NPINS-1:0] next_pin(input logic [NPINS-1:0] g);
        return {g[NPINS-2:0], g[NPINS-1]};  // Pin 33 wraps to pin 0
    endfunction

    function automatic int pin_index(input logic [NPINS-1:0] g);
        int idx;
        int i;
        idx = -1;
        for (i = 0; i < NPINS; i++)
            if (g[i]) idx = i;
        return idx;
    endfunction

    // Galois LFSR, right shift
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Prescaler 1 to 3 from two LFSR bits
    task automatic random_prescale(output int p);
        int i;
        p = 0;
        for (i = 0; i < 2; i++) begin
            p    = (p << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);             // One step per bit
        end
        if (p == 0)
            p = 3;
    endtask

    task automatic value_error(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        err_cnt++;
        $display("** Error %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
    endtask

    task automatic skip_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input gpio_seq_pkg::reg_addr_e a, input logic [15:0] d);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        if (a == gpio_seq_pkg::REG_PRESCALE)
            cur_prescale = int'(d[13:0]);
        @(posedge clk);
        #1 wr_en = 1'b0;
    endtask

    // Zero mask reads without a value check
    task automatic read_check(input string name, input gpio_seq_pkg::reg_addr_e a,
                              input logic [15:0] exp, input logic [15:0] mask);
        int n;
        chk_name = name;
        exp_rd   = exp;
        exp_mask = mask;
        chk_rd   = (mask != '0);
        rd_en    = 1'b1;
        addr     = a;
        @(posedge clk);
        #1 rd_en = 1'b0;
        n = 0;
        while (!rd_valid && n < 4) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!rd_valid) begin
            tmo_cnt++;
            $display("Timeout: read of %s never returned rd_valid", name);
        end
        @(posedge clk);                         // Checker samples rd_valid here
        #1 chk_rd = 1'b0;
    endtask

    // Negative pin waits for irq
    task automatic wait_until(input string what, input int pin, input int limit);
        int n;
        n = 0;
        while (!((pin < 0) ? irq : gpio[pin]) && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!((pin < 0) ? irq : gpio[pin])) begin
            tmo_cnt++;
            $display("Timeout: %s did not happen within %0d cycles", what, limit);
        end
    endtask

    always @(posedge clk) begin
        prev_gpio <= gpio;
        prev_irq  <= irq;
        prev_addr <= addr;
        prev_clr  <= wr_en && addr == gpio_seq_pkg::REG_CMD && wdata[1];
        stop_dly  <= {stop_dly[0], wr_en && addr == gpio_seq_pkg::REG_CMD && wdata[0]};
        hold_cnt  <= (gpio != prev_gpio) ? 1 : hold_cnt + 1;
    end

    a_read_value: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_valid && chk_rd) |-> ((rdata & exp_mask) == exp_rd))
        else value_error(chk_name, 64'($sampled(exp_rd)), 64'($sampled(rdata & exp_mask)));

    a_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(gpio))
        else begin
            err_cnt++;
            $display("** Error one-hot: more than one pin high, gpio %h", $sampled(gpio));
        end

    // Pin to pin handover
    a_pin_order: assert property (@(posedge clk) disable iff (!arst_n)
        (prev_gpio != '0 && gpio != '0 && gpio != prev_gpio) |-> (gpio == next_pin(prev_gpio)))
        else value_error("pin order", 64'(next_pin($sampled(prev_gpio))), 64'($sampled(gpio)));

    a_pin_period: assert property (@(posedge clk) disable iff (!arst_n)
        (prev_gpio != '0 && gpio != '0 && gpio != prev_gpio) |-> (hold_cnt == cur_prescale * TICKS))
        else value_error("pin period", 64'(cur_prescale * TICKS), 64'($sampled(hold_cnt)));

    a_first_pin: assert property (@(posedge clk) disable iff (!arst_n)
        (prev_gpio == '0 && gpio != '0) |-> (gpio == NPINS'(1)))
        else value_error("walk start", 64'(1), 64'($sampled(gpio)));

    // Status pin count against the pin high when the read was taken
    a_status_pin: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_valid && prev_addr == gpio_seq_pkg::REG_STATUS && prev_gpio != '0)
        |-> ({rdata[13:8], rdata[0]} == {6'(pin_index(prev_gpio) + 1), 1'b1}))
        else value_error("status pin count", 64'({6'(pin_index($sampled(prev_gpio)) + 1), 1'b1}),
                         64'({$sampled(rdata[13:8]), $sampled(rdata[0])}));

    a_oneshot_irq: assert property (@(posedge clk) disable iff (!arst_n)
        (prev_gpio[NPINS-1] && gpio == '0) |-> irq)
        else value_error("one-shot irq", 64'(1), 64'($sampled(irq)));

    // irq only rises where a one-shot walk ends
    a_irq_rise: assert property (@(posedge clk) disable iff (!arst_n)
        (!prev_irq && irq) |-> (prev_gpio[NPINS-1] && gpio == '0))
        else value_error("irq rise", 64'(0), 64'($sampled(irq)));

    a_irq_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        (prev_irq && !irq) |-> prev_clr)
        else value_error("irq sticky", 64'(1), 64'($sampled(irq)));

    a_stop_clears: assert property (@(posedge clk) disable iff (!arst_n)
        stop_dly[1] |-> (gpio == '0))
        else value_error("stop clears gpio", 64'(0), 64'($sampled(gpio)));

    a_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        quiet |-> (gpio == '0))
        else value_error("no pin high", 64'(0), 64'($sampled(gpio)));

    initial begin
        arst_n = 1'b0;
        wr_en  = 1'b0;
        rd_en  = 1'b0;
        addr   = '0;
        wdata  = '0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;

        // Reset values and readback
        quiet = 1'b1;
        read_check("status after reset", gpio_seq_pkg::REG_STATUS, 16'h0000, 16'hffff);
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0002);        // One-shot only, no walk
        read_check("ctrl readback", gpio_seq_pkg::REG_CTRL, 16'h0002, 16'hffff);
        write_reg(gpio_seq_pkg::REG_PRESCALE, 16'h2a5c);
        read_check("prescale readback", gpio_seq_pkg::REG_PRESCALE, 16'h2a5c, 16'hffff);
        read_check("cmd read", gpio_seq_pkg::REG_CMD, 16'h0000, 16'hffff);
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0000);
        quiet = 1'b0;

        // Continuous walk across a wrap
        random_prescale(pre);
        write_reg(gpio_seq_pkg::REG_PRESCALE, 16'(pre));
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0001);
        wait_until("pin 3 rising", 3, 1000);
        read_check("status mid-walk", gpio_seq_pkg::REG_STATUS, 16'h0000, 16'h0000);
        wait_until("pin 33 rising", 33, 1000);
        wait_until("wrap to pin 0", 0, 100);
        wait_until("pin 2 after wrap", 2, 100);
        read_check("status after wrap", gpio_seq_pkg::REG_STATUS, 16'h0000, 16'h0000);
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0000);

        // One-shot completion and irq clear
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0003);
        wait_until("one-shot irq", -1, 1000);
        quiet = 1'b1;                                       // Walk over, pins stay low
        read_check("status after one-shot", gpio_seq_pkg::REG_STATUS, 16'h0002, 16'h3f03);
        skip_cycles(20);
        quiet = 1'b0;
        write_reg(gpio_seq_pkg::REG_CMD, 16'h0002);
        read_check("irq clear", gpio_seq_pkg::REG_STATUS, 16'h0000, 16'h0002);
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0000);

        // Stop mid-walk, then restart
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0001);
        wait_until("pin 4 before stop", 4, 1000);
        write_reg(gpio_seq_pkg::REG_CMD, 16'h0001);
        skip_cycles(1);
        quiet = 1'b1;
        read_check("ctrl after stop", gpio_seq_pkg::REG_CTRL, 16'h0000, 16'h0001);
        skip_cycles(40);
        quiet = 1'b0;
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0001);
        wait_until("pin 1 after restart", 1, 1000);
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0000);

        // Zero prescaler holds the walk
        write_reg(gpio_seq_pkg::REG_PRESCALE, 16'h0000);
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0001);
        quiet = 1'b1;
        skip_cycles(100);
        quiet = 1'b0;
        random_prescale(pre);
        write_reg(gpio_seq_pkg::REG_PRESCALE, 16'(pre));
        wait_until("pin 0 after prescale write", 0, 100);
        wait_until("pin 1 after prescale write", 1, 100);
        write_reg(gpio_seq_pkg::REG_CTRL, 16'h0000);
        skip_cycles(4);

        $display("Checks done: %0d value errors, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
design/gpio_seq_pkg.sv
design/flex_counter.sv
design/pin_sequencer.sv
design/seq_config_regs.sv
design/gpio_seq_top.sv
tb/gpio_seq_tb.sv

// ==== Makefile ====
# Verilator flow for the GPIO walking-pin sequencer
VERILATOR ?= verilator
TOP       := gpio_seq_tb
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing -Wall
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED
FAIL_MSG  := TESTS FAILED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	    echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
